// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int xlen           = 32;
    localparam int imem_words     = 64;
    localparam int dmem_words     = 64;
    localparam int imem_addr_bits = $clog2(imem_words);
    localparam int dmem_addr_bits = $clog2(dmem_words);

    typedef enum logic [6:0] {
        opc_load   = 7'd3,
        opc_op_imm = 7'd19,
        opc_store  = 7'd35,
        opc_op     = 7'd51,
        opc_branch = 7'd99,
        opc_jalr   = 7'd103,
        opc_jal    = 7'd111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;      // Also the sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One fetched word, read through whichever format applies
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [2:0] {alu_cls_add = 3'd0, alu_cls_sub = 3'd1, alu_cls_funct = 3'd2}
        alu_class_e;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt} alu_op_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_j} imm_sel_e;

    typedef enum logic [1:0] {res_alu, res_mem, res_pc4} result_sel_e;

    typedef struct packed {
        logic        pc_src;     // Redirect fetch
        result_sel_e result_src;
        logic        mem_write;
        logic        alu_src;    // Operand b from immediate
        imm_sel_e    imm_src;
        logic        reg_write;
        alu_class_e  alu_class;
        logic        jalr;       // Target is rs1 + imm
    } ctrl_t;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pc_src,
    input  logic                         jalr,
    input  logic [rv_core_pkg::xlen-1:0] imm,
    input  logic [rv_core_pkg::xlen-1:0] alu_result,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output logic [rv_core_pkg::xlen-1:0] pc_plus4,
    output rv_core_pkg::instr_u          instr
);

    logic [31:0]                  rom [rv_core_pkg::imem_words];
    logic [rv_core_pkg::xlen-1:0] pc_target;
    logic [rv_core_pkg::xlen-1:0] pc_next;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;        // Branch and jal target

    always_comb begin
        if (!pc_src) begin
            pc_next = pc_plus4;
        end else if (jalr) begin
            pc_next = {alu_result[rv_core_pkg::xlen-1:1], 1'b0};
        end else begin
            pc_next = pc_target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign instr = rom[pc[rv_core_pkg::imem_addr_bits+1:2]];

    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("PC 0x%08h not word aligned", pc);

endmodule

`default_nettype wire

// ==== main_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_core_pkg::opcode_e opcode,
    input  logic                 eq,
    output rv_core_pkg::ctrl_t   ctrl
);

    always_comb begin
        // Everything inactive unless the opcode asks for it
        ctrl.pc_src     = 1'b0;
        ctrl.result_src = rv_core_pkg::res_alu;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.imm_src    = rv_core_pkg::imm_i;
        ctrl.reg_write  = 1'b0;
        ctrl.alu_class  = rv_core_pkg::alu_cls_add;
        ctrl.jalr       = 1'b0;

        unique case (opcode)
            rv_core_pkg::opc_op: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_class  = rv_core_pkg::alu_cls_funct;
            end
            rv_core_pkg::opc_load: begin
                ctrl.result_src = rv_core_pkg::res_mem;
                ctrl.alu_src    = 1'b1;     // Base plus offset
                ctrl.reg_write  = 1'b1;
            end
            rv_core_pkg::opc_op_imm: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_class  = rv_core_pkg::alu_cls_funct;
            end
            rv_core_pkg::opc_store: begin
                ctrl.mem_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_src    = rv_core_pkg::imm_s;
            end
            rv_core_pkg::opc_branch: begin
                ctrl.pc_src     = eq;       // Taken when operands match
                ctrl.imm_src    = rv_core_pkg::imm_b;
                ctrl.alu_class  = rv_core_pkg::alu_cls_sub;
            end
            rv_core_pkg::opc_jalr: begin
                ctrl.pc_src     = 1'b1;
                ctrl.result_src = rv_core_pkg::res_pc4;
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.jalr       = 1'b1;
            end
            rv_core_pkg::opc_jal: begin
                ctrl.pc_src     = 1'b1;
                ctrl.result_src = rv_core_pkg::res_pc4;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_src    = rv_core_pkg::imm_j;
                ctrl.reg_write  = 1'b1;
            end
            default: begin
                // All-zero and unknown words run as a no-op
            end
        endcase
    end

    a_no_store_and_writeback : assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_write && ctrl.reg_write))
        else $error("store and register write in the same cycle");

    a_known_opcode : assert property (@(posedge clk) disable iff (!rst_n)
        opcode inside {rv_core_pkg::opc_op, rv_core_pkg::opc_load, rv_core_pkg::opc_op_imm,
                       rv_core_pkg::opc_store, rv_core_pkg::opc_branch,
                       rv_core_pkg::opc_jalr, rv_core_pkg::opc_jal, 7'd0})
        else $error("illegal opcode %0d", opcode);

endmodule

`default_nettype wire

// ==== imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_extend (
    input  rv_core_pkg::instr_u          instr,
    input  rv_core_pkg::imm_sel_e        imm_src,
    output logic [rv_core_pkg::xlen-1:0] imm
);

    logic sign;

    assign sign = instr.j_fmt.imm_20;   // Instruction bit 31 in every format

    always_comb begin
        unique case (imm_src)
            rv_core_pkg::imm_i: imm = {{20{sign}}, instr.i_fmt.imm_11_0};
            rv_core_pkg::imm_s: imm = {{20{sign}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
            rv_core_pkg::imm_b: begin
                imm = {{19{sign}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            rv_core_pkg::imm_j: begin
                imm = {{11{sign}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  logic [4:0]                   rd,
    input  logic                         we,
    input  logic [rv_core_pkg::xlen-1:0] wd,
    output logic [rv_core_pkg::xlen-1:0] rd1,
    output logic [rv_core_pkg::xlen-1:0] rd2
);

    logic [rv_core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;     // x0 stays zero
        end
    end

    // Asynchronous read, x0 forced to zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic                               clk,
    input  logic                               rst_n,
    input  rv_core_pkg::instr_u                instr,
    input  rv_core_pkg::alu_class_e            alu_class,
    input  logic [rv_core_pkg::xlen-1:0]       a,
    input  logic [rv_core_pkg::xlen-1:0]       b,
    output logic [rv_core_pkg::xlen-1:0]       result,
    output logic                               eq
);

    rv_core_pkg::alu_op_e op;
    logic                 is_r_type;

    assign is_r_type = (instr.r_fmt.opcode == rv_core_pkg::opc_op);

    // Pick the operation actually performed
    always_comb begin
        op = rv_core_pkg::alu_add;
        unique case (alu_class)
            rv_core_pkg::alu_cls_add: op = rv_core_pkg::alu_add;
            rv_core_pkg::alu_cls_sub: op = rv_core_pkg::alu_sub;
            rv_core_pkg::alu_cls_funct: begin
                unique case (instr.r_fmt.funct3)
                    3'b000: begin
                        // addi has no funct7, its immediate lives there
                        if (is_r_type && instr.r_fmt.funct7[5]) begin
                            op = rv_core_pkg::alu_sub;
                        end else begin
                            op = rv_core_pkg::alu_add;
                        end
                    end
                    3'b010:  op = rv_core_pkg::alu_slt;
                    3'b100:  op = rv_core_pkg::alu_xor;
                    3'b110:  op = rv_core_pkg::alu_or;
                    3'b111:  op = rv_core_pkg::alu_and;
                    default: op = rv_core_pkg::alu_add;   // Shifts unsupported
                endcase
            end
            default: op = rv_core_pkg::alu_add;
        endcase
    end

    always_comb begin
        unique case (op)
            rv_core_pkg::alu_add: result = a + b;
            rv_core_pkg::alu_sub: result = a - b;
            rv_core_pkg::alu_and: result = a & b;
            rv_core_pkg::alu_or:  result = a | b;
            rv_core_pkg::alu_xor: result = a ^ b;
            rv_core_pkg::alu_slt: begin
                result = {{(rv_core_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            default: result = a + b;
        endcase
    end

    assign eq = (a == b);   // Branch compare

    a_eq_matches_sub : assert property (@(posedge clk) disable iff (!rst_n)
        (alu_class == rv_core_pkg::alu_cls_sub) |-> (eq == (result == '0)))
        else $error("eq flag disagrees with subtraction result");

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                         clk,
    input  logic                         we,
    input  logic [rv_core_pkg::xlen-1:0] addr,
    input  logic [rv_core_pkg::xlen-1:0] wd,
    output logic [rv_core_pkg::xlen-1:0] rd
);

    logic [rv_core_pkg::xlen-1:0]       mem [rv_core_pkg::dmem_words];
    logic [rv_core_pkg::dmem_addr_bits-1:0] idx;

    assign idx = addr[rv_core_pkg::dmem_addr_bits+1:2];   // Byte address to word

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx];

    // Upper address bits would otherwise alias silently
    a_write_in_range : assert property (@(posedge clk)
        we |-> ((addr >> 2) < rv_core_pkg::dmem_words))
        else $error("store to 0x%08h outside data memory", addr);

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output logic                         mem_write,
    output logic [rv_core_pkg::xlen-1:0] store_addr,
    output logic [rv_core_pkg::xlen-1:0] store_data
);

    rv_core_pkg::instr_u          instr;
    rv_core_pkg::ctrl_t           ctrl;
    logic [rv_core_pkg::xlen-1:0] pc_plus4;
    logic [rv_core_pkg::xlen-1:0] imm;
    logic [rv_core_pkg::xlen-1:0] rd1;
    logic [rv_core_pkg::xlen-1:0] rd2;
    logic [rv_core_pkg::xlen-1:0] alu_b;
    logic [rv_core_pkg::xlen-1:0] alu_result;
    logic [rv_core_pkg::xlen-1:0] read_data;
    logic [rv_core_pkg::xlen-1:0] wb_data;
    logic                         eq;

    fetch_unit u_fetch (.clk(clk), .rst_n(rst_n), .pc_src(ctrl.pc_src), .jalr(ctrl.jalr),
        .imm(imm), .alu_result(alu_result), .pc(pc), .pc_plus4(pc_plus4), .instr(instr));

    main_decoder u_dec (.clk(clk), .rst_n(rst_n), .opcode(instr.r_fmt.opcode), .eq(eq),
        .ctrl(ctrl));

    imm_extend u_imm (.instr(instr), .imm_src(ctrl.imm_src), .imm(imm));

    reg_file u_rf (.clk(clk), .rst_n(rst_n), .rs1(instr.r_fmt.rs1), .rs2(instr.r_fmt.rs2),
        .rd(instr.r_fmt.rd), .we(ctrl.reg_write), .wd(wb_data), .rd1(rd1), .rd2(rd2));

    assign alu_b = ctrl.alu_src ? imm : rd2;

    alu u_alu (.clk(clk), .rst_n(rst_n), .instr(instr), .alu_class(ctrl.alu_class),
        .a(rd1), .b(alu_b), .result(alu_result), .eq(eq));

    data_mem u_dmem (.clk(clk), .we(ctrl.mem_write), .addr(alu_result), .wd(rd2),
        .rd(read_data));

    always_comb begin
        unique case (ctrl.result_src)
            rv_core_pkg::res_mem: wb_data = read_data;
            rv_core_pkg::res_pc4: wb_data = pc_plus4;     // Link address
            default:              wb_data = alu_result;
        endcase
    end

    // Store of the current cycle, taken by memory at the next edge
    assign mem_write  = ctrl.mem_write;
    assign store_addr = alu_result;
    assign store_data = rd2;

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic        mem_write;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    // Expected store stream in program order
    string       exp_name [16];
    logic [31:0] exp_addr [16];
    logic [31:0] exp_data [16];
    int          n_exp;
    int          store_idx;
    int          cycles;

    logic [31:0] c7;
    logic [31:0] c5;
    logic [31:0] prev_pc;
    logic        stepped;       // Previous edge was out of reset

    rv_core dut (.clk(clk), .rst_n(rst_n), .pc(pc), .mem_write(mem_write),
        .store_addr(store_addr), .store_data(store_data));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "%s check failed", name);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic add_expected_store(input string name, input logic [31:0] addr,
                                      input logic [31:0] data);
        exp_name[n_exp] = name;
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // Stores are counted as the memory takes them
    always @(posedge clk) begin
        if (!rst_n) begin
            store_idx <= 0;
        end else if (mem_write) begin
            store_idx <= store_idx + 1;
        end
        prev_pc <= pc;
        stepped <= rst_n;
    end

    // Straight-line code up to the first branch at 0x58
    a_pc_steps : assert property (@(negedge clk) disable iff (!rst_n)
        (stepped && prev_pc < 32'h58) |-> (pc == prev_pc + 32'd4))
        else report_mismatch("pc step", prev_pc + 32'd4, pc);

    a_store_in_list : assert property (@(negedge clk) disable iff (!rst_n)
        mem_write |-> (store_idx < n_exp))
        else report_error($sformatf("Unexpected extra store of 0x%08h to 0x%08h",
                                    store_data, store_addr));

    a_store_addr : assert property (@(negedge clk) disable iff (!rst_n)
        (mem_write && store_idx < n_exp) |-> (store_addr == exp_addr[store_idx]))
        else report_mismatch({exp_name[store_idx], " address"}, exp_addr[store_idx],
                             store_addr);

    a_store_data : assert property (@(negedge clk) disable iff (!rst_n)
        (mem_write && store_idx < n_exp) |-> (store_data == exp_data[store_idx]))
        else report_mismatch({exp_name[store_idx], " data"}, exp_data[store_idx],
                             store_data);

    // The store behind the taken beq holds this marker
    a_no_bad_store : assert property (@(negedge clk) disable iff (!rst_n)
        mem_write |-> (store_data != 32'hBAD))
        else report_error($sformatf("Taken beq did not skip its store, 0xBAD went to 0x%08h",
                                    store_addr));

    initial begin
        rst_n = 1'b0;
        n_exp = 0;
        c7    = 32'd7;
        c5    = 32'd5;

        add_expected_store("add", 32'd0, c7 + c5);
        add_expected_store("sub", 32'd4, c7 - c5);
        add_expected_store("and", 32'd8, c7 & c5);
        add_expected_store("or", 32'd12, c7 | c5);
        add_expected_store("xor", 32'd16, c7 ^ c5);
        add_expected_store("slt", 32'd20, ($signed(c5) < $signed(c7)) ? 32'd1 : 32'd0);
        add_expected_store("addi negative", 32'd24, c7 - 32'd9);
        add_expected_store("slti", 32'd28, ($signed(c7) < -32'sd1) ? 32'd1 : 32'd0);
        add_expected_store("lw reload", 32'd32, c7 + c5);       // Word stored at 0
        add_expected_store("beq untaken", 32'd36, c7);
        add_expected_store("jal link", 32'd40, 32'h68 + 32'd4);  // jal sits at 0x68
        add_expected_store("jalr link", 32'd44, 32'h80 + 32'd4); // jalr sits at 0x80
        add_expected_store("x0 write", 32'd48, 32'd0);

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        assert (pc == 32'd0) else report_mismatch("reset pc", 32'd0, pc);
        assert (!mem_write) else report_mismatch("reset mem_write", 32'd0, {31'b0, mem_write});

        cycles = 0;
        while (pc != 32'h78 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (pc != 32'h78) begin
            report_error("Timeout: the jal loop at PC 0x78 was not reached within 200 cycles");
        end

        // Loop must hold without storing again
        repeat (3) @(negedge clk);
        if (store_idx == n_exp) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_mismatch("store count", n_exp, store_idx);
        end
    end

endmodule

`default_nettype wire

// ==== program.hex ====
// One instruction word per line, word address 0 first
// The text after each word is its address and assembly
00700093  // 00 addi x1, x0, 7
00500113  // 04 addi x2, x0, 5
002081B3  // 08 add  x3, x1, x2
00302023  // 0C sw   x3, 0(x0)
402081B3  // 10 sub  x3, x1, x2
00302223  // 14 sw   x3, 4(x0)
0020F1B3  // 18 and  x3, x1, x2
00302423  // 1C sw   x3, 8(x0)
0020E1B3  // 20 or   x3, x1, x2
00302623  // 24 sw   x3, 12(x0)
0020C1B3  // 28 xor  x3, x1, x2
00302823  // 2C sw   x3, 16(x0)
001121B3  // 30 slt  x3, x2, x1
00302A23  // 34 sw   x3, 20(x0)
FF708213  // 38 addi x4, x1, -9
00402C23  // 3C sw   x4, 24(x0)
FFF0A293  // 40 slti x5, x1, -1
00502E23  // 44 sw   x5, 28(x0)
00002303  // 48 lw   x6, 0(x0)
02602023  // 4C sw   x6, 32(x0)
5D600393  // 50 addi x7, x0, 1494
5D738393  // 54 addi x7, x7, 1495
00208463  // 58 beq  x1, x2, +8
02102223  // 5C sw   x1, 36(x0)
00318463  // 60 beq  x3, x3, +8
02702423  // 64 sw   x7, 40(x0)
0140046F  // 68 jal  x8, +20
02902623  // 6C sw   x9, 44(x0)
06300013  // 70 addi x0, x0, 99
02002823  // 74 sw   x0, 48(x0)
0000006F  // 78 jal  x0, 0
02802423  // 7C sw   x8, 40(x0)
000404E7  // 80 jalr x9, 0(x8)

// ==== rv_core.f ====
rv_core_pkg.sv
fetch_unit.sv
main_decoder.sv
imm_extend.sv
reg_file.sv
alu.sv
data_mem.sv
rv_core.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core and testbench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module tb_rv_core -f rv_core.f -o sim_rv_core \
    && ./obj_dir/sim_rv_core | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    || exit 1
